//--- axis2fib_rxctrl.f
hdl/rx_ctrl_pkg.sv
hdl/fifo_pop_stage.sv
hdl/frame_sequencer.sv
hdl/beat_formatter.sv
hdl/axis2fib_rxctrl.sv
testbench/axis2fib_rxctrl_sva.sv
testbench/tb_axis2fib_rxctrl.sv

//--- Makefile
# Verilator build and run for the rx bridge testbench
# any variable can be overridden, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_axis2fib_rxctrl
FILELIST  ?= axis2fib_rxctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, exit status $$status"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_axis2fib_rxctrl.sv
// rx bridge testbench: FIFO models, random frames and tready, reference beats checked at the stream

`timescale 1ns/10ps

module tb_axis2fib_rxctrl;

    import rx_ctrl_pkg::*;

    localparam int NUM_FRAMES    = 300;
    localparam int MAX_LEN       = 200;
    localparam int BEAT_TIMEOUT  = 2000;    // cycles allowed between two beats
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int IDLE_CYCLES   = 20;

    logic          rx_mac_aclk;
    logic          reset_;
    logic          rden_rf;
    logic          rden_rcf;
    logic          rdempty_rf;
    logic          rdempty_rcf;
    data_word_t    dataout_rf;
    cnt_word_t     dataout_rcf;
    logic          rx_axis_mac_tvalid;
    logic          rx_axis_mac_tready;
    rx_axis_beat_t rx_axis_out;

    integer        seed = 32'hcd68;
    cnt_word_t     cnt_q[$];            // count FIFO contents
    data_word_t    data_q[$];           // data FIFO contents
    rx_axis_beat_t exp_q[$];            // reference beats, in order

    axis2fib_rxctrl u_axis2fib_rxctrl (
        .rx_mac_aclk        (rx_mac_aclk),
        .reset_             (reset_),
        .rden_rf            (rden_rf),
        .rden_rcf           (rden_rcf),
        .rdempty_rf         (rdempty_rf),
        .rdempty_rcf        (rdempty_rcf),
        .dataout_rf         (dataout_rf),
        .dataout_rcf        (dataout_rcf),
        .rx_axis_mac_tvalid (rx_axis_mac_tvalid),
        .rx_axis_mac_tready (rx_axis_mac_tready),
        .rx_axis_out        (rx_axis_out)
    );

    initial begin
        rx_mac_aclk = 1'b0;
        forever #5 rx_mac_aclk = ~rx_mac_aclk;
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_beat(input rx_axis_beat_t got, input rx_axis_beat_t exp, input int idx);
        if (got.tdata !== exp.tdata) begin
            $display("FAILED at %0t ns: rx_axis_out.tdata beat %0d got %h expected %h",
                     $time, idx, got.tdata, exp.tdata);
            abort_run();
        end
        if (got.tstrb !== exp.tstrb) begin
            $display("FAILED at %0t ns: rx_axis_out.tstrb beat %0d got %h expected %h",
                     $time, idx, got.tstrb, exp.tstrb);
            abort_run();
        end
        if (got.tlast !== exp.tlast) begin
            $display("FAILED at %0t ns: rx_axis_out.tlast beat %0d got %b expected %b",
                     $time, idx, got.tlast, exp.tlast);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // low (len mod 8) bits on the last beat, all ones otherwise
    function automatic logic [DATA_BYTES-1:0] expected_strobe(input int len, input bit last_beat);
        int rem;
        rem = len % 8;
        if (!last_beat || rem == 0) begin
            return 8'hff;
        end
        return 8'((1 << rem) - 1);
    endfunction

    task automatic build_frames();
        int            len;
        int            nbeats;
        cnt_word_t     cw;
        data_word_t    dw;
        rx_axis_beat_t b;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (($random(seed) & 15) == 0) begin
                len = 0;                                // force some empty frames
            end else begin
                len = ($random(seed) & 32'h7fffffff) % (MAX_LEN + 1);
            end
            cw = cnt_word_t'($random(seed));            // low half is don't-care
            cw[LEN_LSB +: LEN_WIDTH] = LEN_WIDTH'(len);
            cnt_q.push_back(cw);
            nbeats = (len + 7) / 8;
            for (int k = 0; k < nbeats; k++) begin
                dw = {$random(seed), $random(seed)};
                data_q.push_back(dw);
                b.tdata = dw;
                b.tlast = (k == nbeats - 1);
                b.tstrb = expected_strobe(len, b.tlast);
                exp_q.push_back(b);
            end
        end
    endtask

    // FIFO models with read latency one, random empty gaps, random tready
    always @(posedge rx_mac_aclk) begin
        if (rden_rcf) begin
            if (cnt_q.size() == 0) begin
                $display("read enable raised on the empty count FIFO at %0t ns", $time);
                abort_run();
            end else begin
                dataout_rcf <= cnt_q.pop_front();
            end
        end
        if (rden_rf) begin
            if (data_q.size() == 0) begin
                $display("read enable raised on the empty data FIFO at %0t ns", $time);
                abort_run();
            end else begin
                dataout_rf <= data_q.pop_front();
            end
        end
        rdempty_rcf        <= (cnt_q.size() == 0) || (($random(seed) & 7) == 0);
        rdempty_rf         <= (data_q.size() == 0) || (($random(seed) & 7) == 0);
        rx_axis_mac_tready <= (($random(seed) & 3) != 0);      // about 3 in 4 high
    end

    task automatic wait_transfer(input int idx);
        int cycles;
        cycles = 0;
        @(posedge rx_mac_aclk);
        while (!(rx_axis_mac_tvalid && rx_axis_mac_tready)) begin
            cycles++;
            if (cycles > BEAT_TIMEOUT) begin
                $display("timed out waiting for stream beat %0d at %0t ns", idx, $time);
                abort_run();
            end
            @(posedge rx_mac_aclk);
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (cnt_q.size() != 0 || data_q.size() != 0) begin
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                $display("FIFO models did not drain, %0d count and %0d data words left",
                         cnt_q.size(), data_q.size());
                abort_run();
            end
            @(posedge rx_mac_aclk);
        end
    endtask

    initial begin
        int total;
        reset_             = 1'b0;
        rdempty_rf         = 1'b1;
        rdempty_rcf        = 1'b1;
        dataout_rf         = '0;
        dataout_rcf        = '0;
        rx_axis_mac_tready = 1'b0;
        build_frames();
        total = exp_q.size();

        repeat (3) @(posedge rx_mac_aclk);
        reset_ <= 1'b1;
        check_flag("rx_axis_mac_tvalid", rx_axis_mac_tvalid, 1'b0);

        for (int i = 0; i < total; i++) begin
            wait_transfer(i);
            check_beat(rx_axis_out, exp_q.pop_front(), i);
        end

        // trailing empty frames still have to leave the count FIFO
        wait_drained();
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(posedge rx_mac_aclk);
            check_flag("rx_axis_mac_tvalid", rx_axis_mac_tvalid, 1'b0);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- testbench/axis2fib_rxctrl_sva.sv
// rx bridge assertions: stream stability, strobe, FIFO read rules and quiet outputs in reset

`timescale 1ns/10ps

module axis2fib_rxctrl_sva (
    input logic                       rx_mac_aclk,
    input logic                       reset_,
    input logic                       rden_rf,
    input logic                       rden_rcf,
    input logic                       rdempty_rf,
    input logic                       rdempty_rcf,
    input logic                       rx_axis_mac_tvalid,
    input logic                       rx_axis_mac_tready,
    input rx_ctrl_pkg::rx_axis_beat_t rx_axis_out
);

    // stalled beat holds until taken
    a_stall_stable: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
        (rx_axis_mac_tvalid && !rx_axis_mac_tready) |=>
            (rx_axis_mac_tvalid && $stable(rx_axis_out)))
        else $error("stream beat changed or dropped while stalled");

    a_strb_nonzero: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
        rx_axis_mac_tvalid |-> (rx_axis_out.tstrb != '0))
        else $error("tstrb is zero on a valid beat");

    a_no_read_empty_rf: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
        !(rden_rf && rdempty_rf))
        else $error("data FIFO read while empty");

    a_no_read_empty_rcf: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
        !(rden_rcf && rdempty_rcf))
        else $error("count FIFO read while empty");

    // one edge with reset low is enough to quiet every output
    a_quiet_in_reset: assert property (@(posedge rx_mac_aclk)
        !reset_ |=> (!rden_rf && !rden_rcf && !rx_axis_mac_tvalid))
        else $error("read enable or tvalid high during reset");

endmodule

bind axis2fib_rxctrl axis2fib_rxctrl_sva u_axis2fib_rxctrl_sva (
    .rx_mac_aclk        (rx_mac_aclk),
    .reset_             (reset_),
    .rden_rf            (rden_rf),
    .rden_rcf           (rden_rcf),
    .rdempty_rf         (rdempty_rf),
    .rdempty_rcf        (rdempty_rcf),
    .rx_axis_mac_tvalid (rx_axis_mac_tvalid),
    .rx_axis_mac_tready (rx_axis_mac_tready),
    .rx_axis_out        (rx_axis_out)
);

//--- hdl/axis2fib_rxctrl.sv
// rx bridge top: count and data FIFO stages, frame sequencer and beat formatter to AXI-Stream

`timescale 1ns/10ps

module axis2fib_rxctrl (
    input  logic                       rx_mac_aclk,
    input  logic                       reset_,

    // FIFO read side
    output logic                       rden_rf,         // data FIFO
    output logic                       rden_rcf,        // count FIFO
    input  logic                       rdempty_rf,
    input  logic                       rdempty_rcf,
    input  rx_ctrl_pkg::data_word_t    dataout_rf,
    input  rx_ctrl_pkg::cnt_word_t     dataout_rcf,

    // AXI-Stream output
    output logic                       rx_axis_mac_tvalid,
    input  logic                       rx_axis_mac_tready,
    output rx_ctrl_pkg::rx_axis_beat_t rx_axis_out
);

    import rx_ctrl_pkg::*;

    logic       cnt_valid;
    logic       cnt_ready;
    cnt_word_t  cnt_word;
    logic       data_valid;
    logic       data_ready;
    data_word_t data_word;
    logic       beat_valid;
    logic       beat_ready;
    seq_beat_t  beat;

    // count words, one per frame
    fifo_pop_stage #(.payload_t(cnt_word_t)) u_cnt_stage (
        .rx_mac_aclk (rx_mac_aclk),
        .reset_      (reset_),
        .rdempty     (rdempty_rcf),
        .rden        (rden_rcf),
        .dataout     (dataout_rcf),
        .out_valid   (cnt_valid),
        .out_ready   (cnt_ready),
        .out_data    (cnt_word)
    );

    // 64-bit data words
    fifo_pop_stage #(.payload_t(data_word_t)) u_data_stage (
        .rx_mac_aclk (rx_mac_aclk),
        .reset_      (reset_),
        .rdempty     (rdempty_rf),
        .rden        (rden_rf),
        .dataout     (dataout_rf),
        .out_valid   (data_valid),
        .out_ready   (data_ready),
        .out_data    (data_word)
    );

    frame_sequencer u_frame_sequencer (
        .rx_mac_aclk (rx_mac_aclk),
        .reset_      (reset_),
        .cnt_valid   (cnt_valid),
        .cnt_ready   (cnt_ready),
        .cnt_word    (cnt_word),
        .data_valid  (data_valid),
        .data_ready  (data_ready),
        .data_word   (data_word),
        .beat_valid  (beat_valid),
        .beat_ready  (beat_ready),
        .beat        (beat)
    );

    beat_formatter u_beat_formatter (
        .rx_mac_aclk        (rx_mac_aclk),
        .reset_             (reset_),
        .beat_valid         (beat_valid),
        .beat_ready         (beat_ready),
        .beat               (beat),
        .rx_axis_mac_tvalid (rx_axis_mac_tvalid),
        .rx_axis_mac_tready (rx_axis_mac_tready),
        .rx_axis_out        (rx_axis_out)
    );

endmodule

//--- hdl/beat_formatter.sv
// beat formatter: builds tstrb and tlast and holds stream beats in a two-entry skid buffer

`timescale 1ns/10ps

module beat_formatter (
    input  logic                       rx_mac_aclk,
    input  logic                       reset_,

    // beats from the sequencer
    input  logic                       beat_valid,
    output logic                       beat_ready,
    input  rx_ctrl_pkg::seq_beat_t     beat,

    // AXI-Stream master side
    output logic                       rx_axis_mac_tvalid,
    input  logic                       rx_axis_mac_tready,
    output rx_ctrl_pkg::rx_axis_beat_t rx_axis_out
);

    import rx_ctrl_pkg::*;

    logic [1:0]    count;           // entries held, 0 to 2
    logic          push;
    logic          pop;
    rx_axis_beat_t in_beat;         // formatted incoming beat
    rx_axis_beat_t slot0;           // head, drives the stream
    rx_axis_beat_t slot1;           // skid entry

    // low nbytes bits set, nbytes is 1 to 8
    function automatic logic [DATA_BYTES-1:0] strb_mask(input logic [NB_WIDTH-1:0] nbytes);
        logic [DATA_BYTES-1:0] mask;
        mask = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (i < nbytes) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

    always_comb begin
        in_beat.tdata = beat.data;
        in_beat.tstrb = strb_mask(beat.nbytes);
        in_beat.tlast = beat.last;
    end

    // ready depends on state only, so no path from tready back to the sequencer
    assign beat_ready         = (count != 2'd2);
    assign push               = beat_valid & beat_ready;
    assign rx_axis_mac_tvalid = (count != 2'd0);
    assign pop                = rx_axis_mac_tvalid & rx_axis_mac_tready;
    assign rx_axis_out        = slot0;

    always_ff @(posedge rx_mac_aclk) begin
        if (!reset_) begin
            count <= 2'd0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;       // both or neither
            endcase
        end
    end

    // payload registers, stable while tready is low
    always_ff @(posedge rx_mac_aclk) begin
        case ({push, pop})
            2'b10: begin
                if (count == 2'd0) begin
                    slot0 <= in_beat;
                end else begin
                    slot1 <= in_beat;          // head is stalled, park in skid
                end
            end
            2'b11: begin
                slot0 <= in_beat;              // count is 1 here
            end
            2'b01: begin
                if (count == 2'd2) begin
                    slot0 <= slot1;
                end
            end
            default: begin
                slot0 <= slot0;
            end
        endcase
    end

endmodule

//--- hdl/frame_sequencer.sv
// frame sequencer: takes one count word per frame and forwards that frame's data words as beats

`timescale 1ns/10ps

module frame_sequencer (
    input  logic                   rx_mac_aclk,
    input  logic                   reset_,

    // count words from the count stage
    input  logic                   cnt_valid,
    output logic                   cnt_ready,
    input  rx_ctrl_pkg::cnt_word_t cnt_word,

    // data words from the data stage
    input  logic                   data_valid,
    output logic                   data_ready,
    input  rx_ctrl_pkg::data_word_t data_word,

    // beats toward the formatter
    output logic                   beat_valid,
    input  logic                   beat_ready,
    output rx_ctrl_pkg::seq_beat_t beat
);

    import rx_ctrl_pkg::*;

    // one-hot state encoding
    typedef enum logic [3:0] {
        S_IDLE   = 4'h1,
        S_LOAD   = 4'h2,
        S_STREAM = 4'h4,
        S_DONE   = 4'h8
    } state_t;

    state_t               state;
    state_t               state_nxt;
    logic [LEN_WIDTH-1:0] frame_len;        // length field of the offered count word
    logic [LEN_WIDTH-1:0] rem_bytes;        // bytes still to forward in this frame
    logic                 last_word;
    logic                 cnt_xfer;
    logic                 data_xfer;

    assign frame_len = cnt_word[LEN_LSB +: LEN_WIDTH];

    // count word is taken only in load
    assign cnt_ready = (state == S_LOAD);
    assign cnt_xfer  = cnt_valid & cnt_ready;

    // the final word of a frame carries 1 to 8 bytes
    assign last_word = (rem_bytes <= LEN_WIDTH'(DATA_BYTES));

    // data words pass straight through while streaming
    assign beat_valid = (state == S_STREAM) & data_valid;
    assign data_ready = (state == S_STREAM) & beat_ready;
    assign data_xfer  = data_valid & data_ready;

    always_comb begin
        beat.data   = data_word;
        beat.last   = last_word;
        beat.nbytes = NB_WIDTH'(DATA_BYTES);
        if (last_word) begin
            beat.nbytes = rem_bytes[NB_WIDTH-1:0];  // 8 fits, 4'b1000
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (cnt_valid) begin
                    state_nxt = S_LOAD;
                end
            end
            S_LOAD: begin
                if (cnt_xfer) begin
                    // zero length is consumed with no beats
                    state_nxt = (frame_len == '0) ? S_IDLE : S_STREAM;
                end
            end
            S_STREAM: begin
                if (data_xfer && last_word) begin
                    state_nxt = S_DONE;
                end
            end
            S_DONE: begin
                state_nxt = S_IDLE;
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge rx_mac_aclk) begin
        if (!reset_) begin
            state     <= S_IDLE;
            rem_bytes <= '0;
        end else begin
            state <= state_nxt;
            if (cnt_xfer) begin
                rem_bytes <= frame_len;                     // start of a new frame
            end else if (data_xfer) begin
                if (last_word) begin
                    rem_bytes <= '0;
                end else begin
                    rem_bytes <= rem_bytes - LEN_WIDTH'(DATA_BYTES);
                end
            end
        end
    end

endmodule

//--- hdl/fifo_pop_stage.sv
// fifo pop stage: read-latency-one FIFO with empty flag turned into a two-entry valid/ready source

`timescale 1ns/10ps

module fifo_pop_stage #(
    parameter type payload_t = logic [63:0]
) (
    input  logic     rx_mac_aclk,
    input  logic     reset_,
    input  logic     rdempty,
    output logic     rden,
    input  payload_t dataout,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic       armed;          // set one cycle after reset leaves
    logic       in_flight;      // read issued last cycle, data on dataout now
    logic [1:0] held;           // entries stored, 0 to 2
    logic [1:0] level;          // held entries plus the one in flight
    logic       pop;
    payload_t   slot0;          // oldest entry, presented on out_data
    payload_t   slot1;

    assign pop       = out_valid & out_ready;
    assign level     = held + {1'b0, in_flight};
    assign out_valid = (held != 2'd0);
    assign out_data  = slot0;

    // a pop frees a place in the same cycle, so full rate needs no bubble
    assign rden = armed & ~rdempty & ((level < 2'd2) | pop);

    always_ff @(posedge rx_mac_aclk) begin
        if (!reset_) begin
            armed     <= 1'b0;
            in_flight <= 1'b0;
            held      <= 2'd0;
        end else begin
            armed     <= 1'b1;
            in_flight <= rden;
            held      <= held + {1'b0, in_flight} - {1'b0, pop};
        end
    end

    // entry storage, no reset on payload
    always_ff @(posedge rx_mac_aclk) begin
        if (in_flight) begin
            if (held == 2'd0 || (held == 2'd1 && pop)) begin
                slot0 <= dataout;       // lands directly at the head
            end else begin
                slot1 <= dataout;
            end
        end else if (pop && held == 2'd2) begin
            slot0 <= slot1;             // shift up behind the popped head
        end
    end

endmodule

//--- hdl/rx_ctrl_pkg.sv
// rx control package: widths, constants and payload structs for the receive bridge

package rx_ctrl_pkg;

    // data path, fixed by the 64-bit data FIFO and the 8-bit strobe
    localparam int DATA_WIDTH = 64;
    localparam int DATA_BYTES = DATA_WIDTH / 8;     // also the tstrb width

    // count FIFO word and the length field inside it
    localparam int CNT_WIDTH  = 32;
    localparam int LEN_WIDTH  = 16;
    localparam int LEN_LSB    = 16;                 // length sits in bits 31:16

    // byte count of one beat, 1 to 8
    localparam int NB_WIDTH   = 4;

    // raw FIFO words
    typedef logic [DATA_WIDTH-1:0] data_word_t;
    typedef logic [CNT_WIDTH-1:0]  cnt_word_t;

    // sequencer to formatter
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
        logic [NB_WIDTH-1:0]   nbytes;      // valid bytes in this beat
    } seq_beat_t;

    // outgoing AXI-Stream payload
    typedef struct packed {
        logic [DATA_WIDTH-1:0] tdata;
        logic [DATA_BYTES-1:0] tstrb;
        logic                  tlast;
    } rx_axis_beat_t;

endpackage
